// File: clint_pkg.sv
// Shared definitions for the timer and software interrupt block
// Register map is word based and assumes a 32-bit I/O bus
// Only full word accesses are supported, byte lanes are not decoded

`default_nettype none

package clint_pkg;

   localparam int XLEN = 32;                              // I/O data and address width

   // ------------------------------------------------------------------
   // Register byte offsets from the block base
   // ------------------------------------------------------------------
   localparam logic [XLEN-1:0] MSIP_OFF        = 32'h0000_0000;
   localparam logic [XLEN-1:0] MTIMECMP_LO_OFF = 32'h0000_0008;
   localparam logic [XLEN-1:0] MTIMECMP_HI_OFF = 32'h0000_000C;
   localparam logic [XLEN-1:0] MTIME_LO_OFF    = 32'h0000_0010;
   localparam logic [XLEN-1:0] MTIME_HI_OFF    = 32'h0000_0014;

   localparam logic [XLEN-1:0] MMR_SPAN        = 32'h0000_0020; // Decoded window size

   // Register targeted by a decoded request
   typedef enum logic [2:0] {
      SEL_NONE,
      SEL_MSIP,
      SEL_MTIMECMP_LO,
      SEL_MTIMECMP_HI,
      SEL_MTIME_LO,
      SEL_MTIME_HI
   } mmr_sel_t;

   // 64-bit time word seen as one count or as two bus words
   typedef union packed {
      logic [63:0]      count;                            // Increment and compare view
      struct packed {
         logic [31:0]   hi;
         logic [31:0]   lo;
      } half;                                             // Word write and read view
   } time64_t;

endpackage

`default_nettype wire

// File: mmr_bus_if.sv
// Decoded register access from the request decoder to the register bank
// Strobes are single cycle and at most one of wr, rd or fault is high

`timescale 1ns/1ns
`default_nettype none

interface mmr_bus_if import clint_pkg::*; ();

   logic             wr;                                  // Write strobe
   mmr_sel_t         sel;                                 // Target register
   logic [XLEN-1:0]  wr_data;                             // Store data
   logic             rd;                                  // Read strobe
   logic             fault;                               // Unmapped or misaligned access

   modport decode
   (
      output wr,
      output sel,
      output wr_data,
      output rd,
      output fault
   );

   modport bank
   (
      input  wr,
      input  sel,
      input  wr_data,
      input  rd,
      input  fault
   );

endinterface

`default_nettype wire

// File: mmr_decode.sv
// I/O request decoder for the timer register window
// Expects io_req as a one cycle strobe with exactly one of io_rd or io_wr
// Any address outside the window, misaligned or on a hole answers with fault

`timescale 1ns/1ns
`default_nettype none

module mmr_decode import clint_pkg::*;
#(
   parameter logic [XLEN-1:0] MMR_BASE = 32'h0200_0000   // Window base, word aligned
)
(
   input  logic               clk_in,
   input  logic               reset,
   input  logic               io_req,
   input  logic               io_rd,
   input  logic               io_wr,
   input  logic [XLEN-1:0]    io_addr,
   input  logic [XLEN-1:0]    io_wr_data,
   mmr_bus_if.decode          bus
);

   logic [XLEN-1:0]  offset;                              // Address relative to base
   logic             in_win;
   logic             aligned;
   logic             hit;
   mmr_sel_t         sel_d;

   // ------------------------------------------------------------------
   // Address match
   // ------------------------------------------------------------------
   assign offset  = io_addr - MMR_BASE;
   assign in_win  = (io_addr >= MMR_BASE) && (offset < MMR_SPAN);
   assign aligned = (io_addr[1:0] == 2'b00);

   always_comb
   begin
      case (offset)
         MSIP_OFF:        sel_d = SEL_MSIP;
         MTIMECMP_LO_OFF: sel_d = SEL_MTIMECMP_LO;
         MTIMECMP_HI_OFF: sel_d = SEL_MTIMECMP_HI;
         MTIME_LO_OFF:    sel_d = SEL_MTIME_LO;
         MTIME_HI_OFF:    sel_d = SEL_MTIME_HI;
         default:         sel_d = SEL_NONE;             // Hole inside the window
      endcase
   end

   assign hit = in_win && aligned && (sel_d != SEL_NONE);

   // Strobes, one cycle after the request
   always_ff @(posedge clk_in)
   begin
      if (reset)
      begin
         bus.wr    <= 1'b0;
         bus.rd    <= 1'b0;
         bus.fault <= 1'b0;
      end
      else
      begin
         bus.wr    <= io_req && io_wr && hit;
         bus.rd    <= io_req && io_rd && hit;
         bus.fault <= io_req && !hit;
      end
   end

   // Select and store data only move on a request
   always_ff @(posedge clk_in)
   begin
      if (io_req)
      begin
         bus.sel     <= hit ? sel_d : SEL_NONE;
         bus.wr_data <= io_wr_data;
      end
   end

   // Catches a request carrying both io_rd and io_wr
   a_one_strobe: assert property (@(posedge clk_in) disable iff (reset)
      $onehot0({bus.wr, bus.rd, bus.fault}));

endmodule

`default_nettype wire

// File: mmr_regs.sv
// Register bank for msip, mtimecmp and mtime
// mtime counts once every TICK_DIV clocks, TICK_DIV must be at least 1
// A write to mtime holds off the increment at that edge
// Acknowledge is one cycle after the decoded strobe and cannot stall

`timescale 1ns/1ns
`default_nettype none

module mmr_regs import clint_pkg::*;
#(
   parameter int TICK_DIV = 4                             // Clocks per mtime increment
)
(
   input  logic               clk_in,
   input  logic               reset,
   mmr_bus_if.bank            bus,
   output logic               io_ack,
   output logic               io_ack_fault,
   output logic [XLEN-1:0]    io_ack_data,
   output time64_t            mtime,
   output time64_t            mtimecmp,
   output logic               msip
);

   localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

   logic [DIV_W-1:0] div_cnt;                             // Tick prescaler
   logic             tick;
   logic [XLEN-1:0]  rd_word;

   // ------------------------------------------------------------------
   // Time base
   // ------------------------------------------------------------------
   assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

   always_ff @(posedge clk_in)
   begin
      if (reset || tick)
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 1'b1;
   end

   always_ff @(posedge clk_in)
   begin
      if (reset)
         mtime.count <= '0;
      else if (bus.wr && (bus.sel == SEL_MTIME_LO))
         mtime.half.lo <= bus.wr_data;                    // Upper half holds
      else if (bus.wr && (bus.sel == SEL_MTIME_HI))
         mtime.half.hi <= bus.wr_data;
      else if (tick)
         mtime.count <= mtime.count + 64'd1;
   end

   // ------------------------------------------------------------------
   // Compare value and software interrupt bit
   // ------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (reset)
      begin
         mtimecmp.count <= '1;                            // No timer interrupt out of reset
         msip           <= 1'b0;
      end
      else if (bus.wr)
      begin
         case (bus.sel)
            SEL_MTIMECMP_LO: mtimecmp.half.lo <= bus.wr_data;
            SEL_MTIMECMP_HI: mtimecmp.half.hi <= bus.wr_data;
            SEL_MSIP:        msip             <= bus.wr_data[0];
            default:         ;                            // mtime handled above
         endcase
      end
   end

   // Read mux
   always_comb
   begin
      case (bus.sel)
         SEL_MSIP:        rd_word = {{(XLEN-1){1'b0}}, msip};
         SEL_MTIMECMP_LO: rd_word = mtimecmp.half.lo;
         SEL_MTIMECMP_HI: rd_word = mtimecmp.half.hi;
         SEL_MTIME_LO:    rd_word = mtime.half.lo;
         SEL_MTIME_HI:    rd_word = mtime.half.hi;
         default:         rd_word = '0;
      endcase
   end

   // ------------------------------------------------------------------
   // Acknowledge
   // ------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (reset)
      begin
         io_ack       <= 1'b0;
         io_ack_fault <= 1'b0;
      end
      else
      begin
         io_ack       <= bus.wr || bus.rd || bus.fault;   // Every strobe gets one pulse
         io_ack_fault <= bus.fault;
      end
   end

   always_ff @(posedge clk_in)
      io_ack_data <= bus.rd ? rd_word : '0;               // Zero on writes and faults

   // One request in flight keeps acknowledge a single cycle pulse
   a_ack_single: assert property (@(posedge clk_in) disable iff (reset)
      io_ack |=> !io_ack);

endmodule

`default_nettype wire

// File: irq_halt.sv
// Timer and software interrupt lines plus the CPU halt flag
// timer_irq and sw_irq are registered one clock behind their sources
// Any pending interrupt wakes the CPU and beats a WFI at the same edge

`timescale 1ns/1ns
`default_nettype none

module irq_halt import clint_pkg::*;
(
   input  logic      clk_in,
   input  logic      reset,
   input  logic      ext_irq,                             // External interrupt line
   input  logic      wfi,                                 // Wait for interrupt request
   input  time64_t   mtime,
   input  time64_t   mtimecmp,
   input  logic      msip,
   output logic      timer_irq,
   output logic      sw_irq,
   output logic      cpu_halt
);

   logic             irq_pend;

   // ------------------------------------------------------------------
   // Interrupt lines
   // ------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (reset)
      begin
         timer_irq <= 1'b0;
         sw_irq    <= 1'b0;
      end
      else
      begin
         timer_irq <= (mtime.count >= mtimecmp.count);   // Full 64-bit unsigned compare
         sw_irq    <= msip;
      end
   end

   assign irq_pend = ext_irq || timer_irq || sw_irq;

   // Halt and wake
   always_ff @(posedge clk_in)
   begin
      if (reset || irq_pend)
         cpu_halt <= 1'b0;                                // Wake wins over wfi
      else if (wfi)
         cpu_halt <= 1'b1;
   end

   // A raised timer interrupt holds while mtimecmp stays and mtime only counts up
   a_timer_irq_holds: assert property (@(posedge clk_in) disable iff (reset)
      timer_irq && $stable(mtimecmp.count) && (mtime.count >= $past(mtime.count))
      |=> timer_irq);

endmodule

`default_nettype wire

// File: clint_core.sv
// Top level of the timer and software interrupt peripheral
// Plain I/O request and acknowledge ports, one request in flight at a time
// Request sampled at edge N is acknowledged after edge N+1

`timescale 1ns/1ns
`default_nettype none

module clint_core import clint_pkg::*;
#(
   parameter logic [XLEN-1:0] MMR_BASE = 32'h0200_0000,  // Register window base
   parameter int              TICK_DIV = 4                // Clocks per mtime tick
)
(
   input  logic               clk_in,
   input  logic               reset,

   input  logic               io_req,                     // One cycle request strobe
   input  logic               io_rd,
   input  logic               io_wr,
   input  logic [XLEN-1:0]    io_addr,
   input  logic [XLEN-1:0]    io_wr_data,

   output logic               io_ack,                     // One cycle acknowledge
   output logic               io_ack_fault,
   output logic [XLEN-1:0]    io_ack_data,

   input  logic               ext_irq,
   input  logic               wfi,
   output logic               timer_irq,
   output logic               sw_irq,
   output logic               cpu_halt
);

   time64_t          mtime;
   time64_t          mtimecmp;
   logic             msip;

   mmr_bus_if        mmr_bus ();

   // ------------------------------------------------------------------
   // Decode, register bank, interrupt and halt
   // ------------------------------------------------------------------
   mmr_decode #(.MMR_BASE(MMR_BASE)) u_decode
   (
      .clk_in(clk_in), .reset(reset),
      .io_req(io_req), .io_rd(io_rd), .io_wr(io_wr),
      .io_addr(io_addr), .io_wr_data(io_wr_data),
      .bus(mmr_bus.decode)
   );

   mmr_regs #(.TICK_DIV(TICK_DIV)) u_regs
   (
      .clk_in(clk_in), .reset(reset),
      .bus(mmr_bus.bank),
      .io_ack(io_ack), .io_ack_fault(io_ack_fault), .io_ack_data(io_ack_data),
      .mtime(mtime), .mtimecmp(mtimecmp), .msip(msip)
   );

   irq_halt u_irq_halt
   (
      .clk_in(clk_in), .reset(reset),
      .ext_irq(ext_irq), .wfi(wfi),
      .mtime(mtime), .mtimecmp(mtimecmp), .msip(msip),
      .timer_irq(timer_irq), .sw_irq(sw_irq), .cpu_halt(cpu_halt)
   );

endmodule

`default_nettype wire

// File: tb_checker.sv
// Checker for the CLINT testbench
// Watches the DUT ports and compares them with the expectations the top drives
// An acknowledge must follow a sampled request by exactly two clocks
// Expectation inputs must only change by non-blocking assignment on the clock edge

`timescale 1ns/1ns
`default_nettype none

module tb_checker
(
   input  logic         clk_in,
   input  logic         reset,
   input  logic         io_req,
   input  logic         io_ack,
   input  logic         io_ack_fault,
   input  logic [31:0]  io_ack_data,
   input  logic         timer_irq,
   input  logic         sw_irq,
   input  logic         cpu_halt,
   input  logic [127:0] test_name,                        // ASCII, right aligned
   input  logic         exp_fault,
   input  logic [31:0]  exp_lo,                           // Accepted read data range
   input  logic [31:0]  exp_hi,
   input  logic         line_chk,                         // Compare the lines at this edge
   input  logic [2:0]   line_mask,                        // {timer_irq, sw_irq, cpu_halt}
   input  logic [2:0]   line_exp,
   output int           err_cnt,
   output int           chk_cnt
);

   int            errs = 0;
   int            checks = 0;
   logic [1:0]    req_pipe;                               // Requests seen one and two edges ago
   logic [2:0]    lines;

   assign lines   = {timer_irq, sw_irq, cpu_halt};
   assign err_cnt = errs;
   assign chk_cnt = checks;

   // ------------------------------------------------------------------
   // Acknowledge timing, fault flag, read data and interrupt lines
   // ------------------------------------------------------------------
   always @(posedge clk_in)
   begin
      if (reset)
         req_pipe <= 2'b00;
      else
      begin
         req_pipe <= {req_pipe[0], io_req};
         if (req_pipe[1] && !io_ack)
         begin
            errs = errs + 1;
            $display("%0s: no acknowledge two clocks after the request", test_name);
         end
         else if (io_ack && !req_pipe[1])
         begin
            errs = errs + 1;
            $display("%0s: acknowledge without a request two clocks before", test_name);
         end
         else if (io_ack)
         begin
            checks = checks + 1;
            if (io_ack_fault !== exp_fault)
            begin
               errs = errs + 1;
               $display("ERR %0s fault expected %b actual %b",
                        test_name, exp_fault, io_ack_fault);
            end
            if ($isunknown(io_ack_data) || (io_ack_data < exp_lo) || (io_ack_data > exp_hi))
            begin
               errs = errs + 1;
               if (exp_lo == exp_hi)
                  $display("ERR %0s expected %h actual %h", test_name, exp_lo, io_ack_data);
               else
                  $display("ERR %0s expected %h..%h actual %h",
                           test_name, exp_lo, exp_hi, io_ack_data);
            end
         end
         if (line_chk)                                    // Only the masked lines count
         begin
            checks = checks + 1;
            if ((lines & line_mask) !== (line_exp & line_mask))
            begin
               errs = errs + 1;
               $display("ERR %0s expected %b actual %b (mask %b)",
                        test_name, line_exp & line_mask, lines & line_mask, line_mask);
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_clint.sv
// Testbench for the CLINT peripheral
// Applies a table of register accesses and interrupt or halt steps in order
// Assumes the top level defaults, MMR_BASE 0x0200_0000 and TICK_DIV 4
// Random data comes from a fixed seed LFSR, so every run is identical

`timescale 1ns/1ns
`default_nettype none

module tb_clint;

   localparam logic [31:0] MMR_BASE     = 32'h0200_0000;
   localparam int          TICK_DIV     = 4;
   localparam int          RESET_CYCLES = 4;
   localparam int          ACK_WAIT     = 8;              // Clocks allowed for io_ack

   localparam logic [31:0] A_MSIP    = MMR_BASE + 32'h00;
   localparam logic [31:0] A_CMP_LO  = MMR_BASE + 32'h08;
   localparam logic [31:0] A_CMP_HI  = MMR_BASE + 32'h0C;
   localparam logic [31:0] A_TIME_LO = MMR_BASE + 32'h10;
   localparam logic [31:0] A_TIME_HI = MMR_BASE + 32'h14;

   localparam logic [2:0]  OP_WR       = 3'd0;
   localparam logic [2:0]  OP_RD       = 3'd1;
   localparam logic [2:0]  OP_WFI      = 3'd2;            // One cycle wfi, then line check
   localparam logic [2:0]  OP_EXT      = 3'd3;            // One cycle ext_irq, then line check
   localparam logic [2:0]  OP_LINES    = 3'd4;
   localparam logic [2:0]  OP_WAIT_TMR = 3'd5;            // Wait up to data cycles for timer_irq
   localparam logic [2:0]  OP_RD_TIME  = 3'd6;            // mtime lo read against a range

   typedef struct packed {
      logic [127:0]  name;
      logic [2:0]    op;
      logic [31:0]   addr;
      logic [31:0]   data;
      logic [31:0]   exp;                                 // Read data, or lines in [2:0]
      logic          fault;
      logic [2:0]    mask;
   } test_t;

   logic          clk_in;
   logic          reset;
   logic          io_req;
   logic          io_rd;
   logic          io_wr;
   logic [31:0]   io_addr;
   logic [31:0]   io_wr_data;
   logic          io_ack;
   logic          io_ack_fault;
   logic [31:0]   io_ack_data;
   logic          ext_irq;
   logic          wfi;
   logic          timer_irq;
   logic          sw_irq;
   logic          cpu_halt;

   logic [127:0]  test_name;                              // Expectations handed to the checker
   logic          exp_fault;
   logic [31:0]   exp_lo;
   logic [31:0]   exp_hi;
   logic          line_chk;
   logic [2:0]    line_mask;
   logic [2:0]    line_exp;
   int            err_cnt;
   int            chk_cnt;

   test_t         tests[$];
   logic [31:0]   lfsr_state;
   int            cycle_cnt = 0;
   int            cycle_limit = 1000;
   int            mark_cycle;                             // Cycle of the mtime lo write

   clint_core uut
   (
      .clk_in(clk_in), .reset(reset),
      .io_req(io_req), .io_rd(io_rd), .io_wr(io_wr),
      .io_addr(io_addr), .io_wr_data(io_wr_data),
      .io_ack(io_ack), .io_ack_fault(io_ack_fault), .io_ack_data(io_ack_data),
      .ext_irq(ext_irq), .wfi(wfi),
      .timer_irq(timer_irq), .sw_irq(sw_irq), .cpu_halt(cpu_halt)
   );

   tb_checker u_check
   (
      .clk_in(clk_in), .reset(reset),
      .io_req(io_req), .io_ack(io_ack), .io_ack_fault(io_ack_fault),
      .io_ack_data(io_ack_data),
      .timer_irq(timer_irq), .sw_irq(sw_irq), .cpu_halt(cpu_halt),
      .test_name(test_name), .exp_fault(exp_fault), .exp_lo(exp_lo), .exp_hi(exp_hi),
      .line_chk(line_chk), .line_mask(line_mask), .line_exp(line_exp),
      .err_cnt(err_cnt), .chk_cnt(chk_cnt)
   );

   initial
   begin
      clk_in = 1'b0;
      forever #50 clk_in = ~clk_in;                       // 100 ns period
   end

   always @(posedge clk_in)
      cycle_cnt <= cycle_cnt + 1;

   // ------------------------------------------------------------------
   // Random data and the test table
   // ------------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);   // Galois form
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      for (int i = 0; i < 32; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);              // One step per bit
         w[i]       = lfsr_state[0];
      end
      return w;
   endfunction

   task automatic add_test(input logic [127:0] name, input logic [2:0] op,
                           input logic [31:0] addr, input logic [31:0] data,
                           input logic [31:0] exp, input logic fault, input logic [2:0] mask);
      tests.push_back('{name, op, addr, data, exp, fault, mask});
   endtask

   task automatic build_tests();
      logic [31:0] r_lo;
      logic [31:0] r_hi;
      logic [31:0] r_sw;
      logic [31:0] v;
      r_lo = rand_word();
      r_hi = rand_word() | 32'h8000_0000;                 // Keeps the compare far above mtime
      r_sw = rand_word() | 32'h0000_0001;
      v    = rand_word() & 32'h0FFF_FFFF;                 // Room for V plus 8 in the low word
      add_test("cmp_lo_wr", OP_WR, A_CMP_LO, r_lo, 32'h0, 1'b0, 3'b000);
      add_test("cmp_hi_wr", OP_WR, A_CMP_HI, r_hi, 32'h0, 1'b0, 3'b000);
      add_test("cmp_lo_rd", OP_RD, A_CMP_LO, 32'h0, r_lo, 1'b0, 3'b000);
      add_test("cmp_hi_rd", OP_RD, A_CMP_HI, 32'h0, r_hi, 1'b0, 3'b000);
      // Faults, then check nothing moved
      add_test("hole_rd", OP_RD, MMR_BASE + 32'h04, 32'h0, 32'h0, 1'b1, 3'b000);
      add_test("hole_wr", OP_WR, MMR_BASE + 32'h18, rand_word(), 32'h0, 1'b1, 3'b000);
      add_test("outside_wr", OP_WR, MMR_BASE + 32'h20, rand_word(), 32'h0, 1'b1, 3'b000);
      add_test("below_rd", OP_RD, MMR_BASE - 32'h04, 32'h0, 32'h0, 1'b1, 3'b000);
      add_test("misalign_wr", OP_WR, A_CMP_LO + 32'h1, rand_word(), 32'h0, 1'b1, 3'b000);
      add_test("cmp_lo_keep", OP_RD, A_CMP_LO, 32'h0, r_lo, 1'b0, 3'b000);
      add_test("cmp_hi_keep", OP_RD, A_CMP_HI, 32'h0, r_hi, 1'b0, 3'b000);
      add_test("msip_keep", OP_RD, A_MSIP, 32'h0, 32'h0, 1'b0, 3'b000);
      // Software interrupt
      add_test("msip_set", OP_WR, A_MSIP, r_sw, 32'h0, 1'b0, 3'b000);
      add_test("sw_irq_high", OP_LINES, 32'h0, 32'h0, 32'h2, 1'b0, 3'b010);
      add_test("msip_rd1", OP_RD, A_MSIP, 32'h0, 32'h1, 1'b0, 3'b000);
      add_test("msip_clr", OP_WR, A_MSIP, 32'h0, 32'h0, 1'b0, 3'b000);
      add_test("sw_irq_low", OP_LINES, 32'h0, 32'h0, 32'h0, 1'b0, 3'b010);
      add_test("msip_rd0", OP_RD, A_MSIP, 32'h0, 32'h0, 1'b0, 3'b000);
      // Halt and wake
      add_test("idle_lines", OP_LINES, 32'h0, 32'h0, 32'h0, 1'b0, 3'b111);
      add_test("wfi_halt", OP_WFI, 32'h0, 32'h0, 32'h1, 1'b0, 3'b111);
      add_test("ext_wake", OP_EXT, 32'h0, 32'h0, 32'h0, 1'b0, 3'b001);
      add_test("msip_set2", OP_WR, A_MSIP, 32'h1, 32'h0, 1'b0, 3'b000);
      add_test("wfi_blocked", OP_WFI, 32'h0, 32'h0, 32'h2, 1'b0, 3'b011);
      add_test("msip_clr2", OP_WR, A_MSIP, 32'h0, 32'h0, 1'b0, 3'b000);
      // Timer interrupt against mtime = V
      add_test("mtime_hi_wr", OP_WR, A_TIME_HI, 32'h0, 32'h0, 1'b0, 3'b000);
      add_test("mtime_lo_wr", OP_WR, A_TIME_LO, v, 32'h0, 1'b0, 3'b000);
      add_test("cmp_lo_ones", OP_WR, A_CMP_LO, 32'hFFFF_FFFF, 32'h0, 1'b0, 3'b000);
      add_test("cmp_hi_ones", OP_WR, A_CMP_HI, 32'hFFFF_FFFF, 32'h0, 1'b0, 3'b000);
      add_test("timer_quiet", OP_LINES, 32'h0, 32'h0, 32'h0, 1'b0, 3'b100);
      add_test("cmp_lo_near", OP_WR, A_CMP_LO, v + 32'd8, 32'h0, 1'b0, 3'b000);
      add_test("cmp_hi_near", OP_WR, A_CMP_HI, 32'h0, 32'h0, 1'b0, 3'b000);
      add_test("timer_fire", OP_WAIT_TMR, 32'h0, 8 * TICK_DIV + 10, 32'h4, 1'b0, 3'b100);
      add_test("mtime_lo_rd", OP_RD_TIME, A_TIME_LO, v, 32'h0, 1'b0, 3'b000);
      add_test("mtime_hi_rd", OP_RD, A_TIME_HI, 32'h0, 32'h0, 1'b0, 3'b000);
   endtask

   // ------------------------------------------------------------------
   // Stimulus, driven right after a rising edge
   // ------------------------------------------------------------------
   task automatic do_request(input test_t t, input logic [31:0] lo, input logic [31:0] hi);
      int waited;
      if ((t.op == OP_WR) && (t.addr == A_TIME_LO))
         mark_cycle = cycle_cnt;                          // Start of the elapsed time window
      test_name  <= t.name;
      exp_fault  <= t.fault;
      exp_lo     <= lo;
      exp_hi     <= hi;
      io_req     <= 1'b1;
      io_rd      <= (t.op != OP_WR);
      io_wr      <= (t.op == OP_WR);
      io_addr    <= t.addr;
      io_wr_data <= t.data;
      @(posedge clk_in);
      io_req <= 1'b0;
      io_rd  <= 1'b0;
      io_wr  <= 1'b0;
      waited = 0;
      do
      begin
         @(posedge clk_in);
         waited++;
      end
      while (!io_ack && (waited < ACK_WAIT));             // Checker flags a late or lost ack
   endtask

   task automatic check_lines(input logic [127:0] name, input logic [2:0] mask,
                              input logic [2:0] exp);
      test_name <= name;
      line_mask <= mask;
      line_exp  <= exp;
      line_chk  <= 1'b1;
      @(posedge clk_in);
      line_chk  <= 1'b0;
   endtask

   task automatic run_test(input test_t t);
      int waited;
      case (t.op)
         OP_WR, OP_RD:
            do_request(t, t.exp, t.exp);
         OP_RD_TIME:                                      // At most one tick per TICK_DIV clocks
            do_request(t, t.data, t.data + (cycle_cnt - mark_cycle) / TICK_DIV + 1);
         OP_WFI, OP_EXT:
         begin
            if (t.op == OP_WFI)
               wfi <= 1'b1;
            else
               ext_irq <= 1'b1;
            @(posedge clk_in);
            wfi     <= 1'b0;
            ext_irq <= 1'b0;
            check_lines(t.name, t.mask, t.exp[2:0]);
         end
         OP_WAIT_TMR:
         begin
            waited = 0;
            while (!timer_irq && (waited < t.data))
            begin
               @(posedge clk_in);
               waited++;
            end
            check_lines(t.name, t.mask, t.exp[2:0]);
         end
         default:
            check_lines(t.name, t.mask, t.exp[2:0]);
      endcase
   endtask

   initial
   begin
      reset      = 1'b1;
      io_req     = 1'b0;
      io_rd      = 1'b0;
      io_wr      = 1'b0;
      io_addr    = 32'h0;
      io_wr_data = 32'h0;
      ext_irq    = 1'b0;
      wfi        = 1'b0;
      test_name  = '0;
      exp_fault  = 1'b0;
      exp_lo     = 32'h0;
      exp_hi     = 32'h0;
      line_chk   = 1'b0;
      line_mask  = 3'b000;
      line_exp   = 3'b000;
      mark_cycle = 0;
      lfsr_state = 32'hd6c5;
      build_tests();
      cycle_limit = tests.size() * 20 + RESET_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk_in);
      reset <= 1'b0;
      for (int i = 0; i < tests.size(); i++)
         run_test(tests[i]);
      repeat (4) @(posedge clk_in);                       // Let the last checks land
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   // Watchdog
   initial
   begin
      @(posedge clk_in);
      while (cycle_cnt < cycle_limit)
         @(posedge clk_in);
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt + 1);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
clint_pkg.sv
mmr_bus_if.sv
mmr_decode.sv
mmr_regs.sv
irq_halt.sv
clint_core.sv
tb_checker.sv
tb_clint.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the CLINT testbench with Verilator.
# Pass or fail is taken from the simulation log.

set -u
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log
rm -f "$build_log" "$sim_log"

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module tb_clint -f sim.f -o tb_clint_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see $build_log"
   exit 1
fi

./obj_dir/tb_clint_sim > "$sim_log" 2>&1
run_status=$?
cat "$sim_log"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qx "Simulation completed successfully" "$sim_log"; then
   exit 0
fi
exit 1
